//--- rob_pkg.sv
package rob_pkg;

    // datapath widths
    localparam int DATA_W = 32;
    localparam int REG_W = 4;
    localparam int NUM_REGS = 1 << REG_W;

    // reorder buffer geometry, tag indexes an entry directly
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W = 3;

    // multiplier pipeline depth
    localparam int MUL_LAT = 3;

    localparam int OP_W = 3;

    // opcodes, operands arrive already resolved
    typedef enum logic [OP_W-1:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_MUL = 3'd3,
        OP_BEQ = 3'd4 // no writeback, taken when a == b
    } op_e;

endpackage

//--- dispatch_stage.sv
`timescale 1ns/10ps

module dispatch_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,

    input  logic                        in_valid,
    input  rob_pkg::op_e                in_op,
    input  logic [rob_pkg::REG_W-1:0]   in_rd,
    input  logic [rob_pkg::DATA_W-1:0]  in_a,
    input  logic [rob_pkg::DATA_W-1:0]  in_b,
    input  logic                        in_pred_taken,
    output logic                        in_ready,

    input  logic                        alloc_ready,
    input  logic [rob_pkg::TAG_W-1:0]   alloc_tag,
    output logic                        alloc_en,
    output rob_pkg::op_e                alloc_op,
    output logic [rob_pkg::REG_W-1:0]   alloc_rd,
    output logic                        alloc_pred,

    output logic                        issue_en,
    output rob_pkg::op_e                issue_op,
    output logic [rob_pkg::TAG_W-1:0]   issue_tag,
    output logic [rob_pkg::DATA_W-1:0]  issue_a,
    output logic [rob_pkg::DATA_W-1:0]  issue_b
);

    logic accept;
    logic issue_vld;

    // full buffer or redirect in progress stalls the front
    assign in_ready = alloc_ready & ~flush;
    assign accept   = in_valid & in_ready;

    // entry is written into the rob in the accept cycle
    assign alloc_en   = accept;
    assign alloc_op   = in_op;
    assign alloc_rd   = in_rd;
    assign alloc_pred = in_pred_taken;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issue_vld <= 1'b0;
        end else begin
            issue_vld <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue_op  <= in_op;
            issue_tag <= alloc_tag; // tag granted this cycle
            issue_a   <= in_a;
            issue_b   <= in_b;
        end
    end

    // anything issuing under flush is younger than the branch
    assign issue_en = issue_vld & ~flush;

endmodule

//--- exec_stage.sv
`timescale 1ns/10ps

module exec_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,

    input  logic                        issue_en,
    input  rob_pkg::op_e                issue_op,
    input  logic [rob_pkg::TAG_W-1:0]   issue_tag,
    input  logic [rob_pkg::DATA_W-1:0]  issue_a,
    input  logic [rob_pkg::DATA_W-1:0]  issue_b,

    output logic                        alu_done,
    output logic [rob_pkg::TAG_W-1:0]   alu_tag,
    output logic [rob_pkg::DATA_W-1:0]  alu_data,
    output logic                        alu_taken,

    output logic                        mul_done,
    output logic [rob_pkg::TAG_W-1:0]   mul_tag,
    output logic [rob_pkg::DATA_W-1:0]  mul_data
);

    logic                        is_mul;
    logic [rob_pkg::DATA_W-1:0]  alu_res;
    logic                        alu_cmp;

    logic [rob_pkg::MUL_LAT-1:0] mul_vld;
    logic [rob_pkg::TAG_W-1:0]   mul_tag_q  [rob_pkg::MUL_LAT];
    logic [rob_pkg::DATA_W-1:0]  mul_prod_q [rob_pkg::MUL_LAT];

    assign is_mul = (issue_op == rob_pkg::OP_MUL);

    always_comb begin
        alu_res = '0;
        alu_cmp = 1'b0;
        case (issue_op)
            rob_pkg::OP_ADD: alu_res = issue_a + issue_b;
            rob_pkg::OP_SUB: alu_res = issue_a - issue_b;
            rob_pkg::OP_XOR: alu_res = issue_a ^ issue_b;
            rob_pkg::OP_BEQ: alu_cmp = (issue_a == issue_b);
            default: alu_res = '0;
        endcase
    end

    // single cycle alu
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= issue_en & ~is_mul;
        end
    end

    always_ff @(posedge clk) begin
        alu_tag   <= issue_tag;
        alu_data  <= alu_res;
        alu_taken <= alu_cmp;
    end

    // multiplier valids, cleared on flush so squashed ops never complete
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_vld <= '0;
        end else begin
            mul_vld <= {mul_vld[rob_pkg::MUL_LAT-2:0], issue_en & is_mul};
        end
    end

    always_ff @(posedge clk) begin
        mul_tag_q[0]  <= issue_tag;
        mul_prod_q[0] <= issue_a * issue_b; // low half only
        for (int s = 1; s < rob_pkg::MUL_LAT; s++) begin
            mul_tag_q[s]  <= mul_tag_q[s-1];
            mul_prod_q[s] <= mul_prod_q[s-1];
        end
    end

    assign mul_done = mul_vld[rob_pkg::MUL_LAT-1];
    assign mul_tag  = mul_tag_q[rob_pkg::MUL_LAT-1];
    assign mul_data = mul_prod_q[rob_pkg::MUL_LAT-1];

endmodule

//--- reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,

    input  logic                        alloc_en,
    input  rob_pkg::op_e                alloc_op,
    input  logic [rob_pkg::REG_W-1:0]   alloc_rd,
    input  logic                        alloc_pred,
    output logic                        alloc_ready,
    output logic [rob_pkg::TAG_W-1:0]   alloc_tag,

    input  logic                        alu_done,
    input  logic [rob_pkg::TAG_W-1:0]   alu_tag,
    input  logic [rob_pkg::DATA_W-1:0]  alu_data,
    input  logic                        alu_taken,

    input  logic                        mul_done,
    input  logic [rob_pkg::TAG_W-1:0]   mul_tag,
    input  logic [rob_pkg::DATA_W-1:0]  mul_data,

    output logic                        ret_en,
    output logic [rob_pkg::REG_W-1:0]   ret_rd,
    output logic [rob_pkg::DATA_W-1:0]  ret_data,
    output logic                        ret_wb,
    output logic                        ret_mispredict
);

    logic [rob_pkg::ROB_DEPTH-1:0] busy;
    logic [rob_pkg::ROB_DEPTH-1:0] done;
    logic [rob_pkg::ROB_DEPTH-1:0] wb;
    logic [rob_pkg::ROB_DEPTH-1:0] pred;
    logic [rob_pkg::ROB_DEPTH-1:0] act;
    logic [rob_pkg::REG_W-1:0]     rd_q   [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::DATA_W-1:0]    data_q [rob_pkg::ROB_DEPTH];

    logic [rob_pkg::TAG_W-1:0]     head;
    logic [rob_pkg::TAG_W-1:0]     tail;
    logic [rob_pkg::TAG_W:0]       count;

    assign alloc_ready = (count != (rob_pkg::TAG_W+1)'(rob_pkg::ROB_DEPTH));
    assign alloc_tag   = tail;

    // head leaves as soon as its result is in, held off while flushing
    assign ret_en         = busy[head] & done[head] & ~flush;
    assign ret_rd         = rd_q[head];
    assign ret_data       = data_q[head];
    assign ret_wb         = wb[head];
    assign ret_mispredict = ~wb[head] & (pred[head] != act[head]); // branches only

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy  <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alu_done) done[alu_tag] <= 1'b1;
            if (mul_done) done[mul_tag] <= 1'b1;
            if (alloc_en) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (ret_en) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            case ({alloc_en, ret_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            rd_q[tail] <= alloc_rd;
            wb[tail]   <= (alloc_op != rob_pkg::OP_BEQ);
            pred[tail] <= alloc_pred;
        end
        if (alu_done) begin
            data_q[alu_tag] <= alu_data;
            act[alu_tag]    <= alu_taken;
        end
        if (mul_done) begin
            data_q[mul_tag] <= mul_data;
            act[mul_tag]    <= 1'b0;
        end
    end

endmodule

//--- retire_stage.sv
`timescale 1ns/10ps

module retire_stage (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        ret_en,
    input  logic [rob_pkg::REG_W-1:0]   ret_rd,
    input  logic [rob_pkg::DATA_W-1:0]  ret_data,
    input  logic                        ret_wb,
    input  logic                        ret_mispredict,

    output logic                        commit_valid,
    output logic [rob_pkg::REG_W-1:0]   commit_rd,
    output logic [rob_pkg::DATA_W-1:0]  commit_data,
    output logic                        flush,

    input  logic [rob_pkg::REG_W-1:0]   rf_addr,
    output logic [rob_pkg::DATA_W-1:0]  rf_data
);

    logic [rob_pkg::DATA_W-1:0] rf [rob_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= ret_en & ret_wb;
            flush        <= ret_en & ret_mispredict; // single pulse, rob stops retiring
        end
    end

    always_ff @(posedge clk) begin
        commit_rd   <= ret_rd;
        commit_data <= ret_data;
    end

    // architectural state, zero out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < rob_pkg::NUM_REGS; r++) begin
                rf[r] <= '0;
            end
        end else if (ret_en && ret_wb) begin
            rf[ret_rd] <= ret_data;
        end
    end

    assign rf_data = rf[rf_addr];

endmodule

//--- ooo_backend_top.sv
`timescale 1ns/10ps

module ooo_backend_top (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        in_valid,
    output logic                        in_ready,
    input  rob_pkg::op_e                in_op,
    input  logic [rob_pkg::REG_W-1:0]   in_rd,
    input  logic [rob_pkg::DATA_W-1:0]  in_a,
    input  logic [rob_pkg::DATA_W-1:0]  in_b,
    input  logic                        in_pred_taken,

    output logic                        commit_valid,
    output logic [rob_pkg::REG_W-1:0]   commit_rd,
    output logic [rob_pkg::DATA_W-1:0]  commit_data,
    output logic                        flush,

    input  logic [rob_pkg::REG_W-1:0]   rf_addr,
    output logic [rob_pkg::DATA_W-1:0]  rf_data
);

    // dispatch to rob
    logic                        alloc_en;
    logic                        alloc_ready;
    logic [rob_pkg::TAG_W-1:0]   alloc_tag;
    rob_pkg::op_e                alloc_op;
    logic [rob_pkg::REG_W-1:0]   alloc_rd;
    logic                        alloc_pred;

    // dispatch to execute
    logic                        issue_en;
    rob_pkg::op_e                issue_op;
    logic [rob_pkg::TAG_W-1:0]   issue_tag;
    logic [rob_pkg::DATA_W-1:0]  issue_a;
    logic [rob_pkg::DATA_W-1:0]  issue_b;

    // completion ports
    logic                        alu_done;
    logic [rob_pkg::TAG_W-1:0]   alu_tag;
    logic [rob_pkg::DATA_W-1:0]  alu_data;
    logic                        alu_taken;
    logic                        mul_done;
    logic [rob_pkg::TAG_W-1:0]   mul_tag;
    logic [rob_pkg::DATA_W-1:0]  mul_data;

    // retire port
    logic                        ret_en;
    logic [rob_pkg::REG_W-1:0]   ret_rd;
    logic [rob_pkg::DATA_W-1:0]  ret_data;
    logic                        ret_wb;
    logic                        ret_mispredict;

    dispatch_stage i_dispatch (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_rd         (in_rd),
        .in_a          (in_a),
        .in_b          (in_b),
        .in_pred_taken (in_pred_taken),
        .in_ready      (in_ready),
        .alloc_ready   (alloc_ready),
        .alloc_tag     (alloc_tag),
        .alloc_en      (alloc_en),
        .alloc_op      (alloc_op),
        .alloc_rd      (alloc_rd),
        .alloc_pred    (alloc_pred),
        .issue_en      (issue_en),
        .issue_op      (issue_op),
        .issue_tag     (issue_tag),
        .issue_a       (issue_a),
        .issue_b       (issue_b)
    );

    exec_stage i_exec (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .issue_en  (issue_en),
        .issue_op  (issue_op),
        .issue_tag (issue_tag),
        .issue_a   (issue_a),
        .issue_b   (issue_b),
        .alu_done  (alu_done),
        .alu_tag   (alu_tag),
        .alu_data  (alu_data),
        .alu_taken (alu_taken),
        .mul_done  (mul_done),
        .mul_tag   (mul_tag),
        .mul_data  (mul_data)
    );

    reorder_buffer i_rob (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .alloc_en       (alloc_en),
        .alloc_op       (alloc_op),
        .alloc_rd       (alloc_rd),
        .alloc_pred     (alloc_pred),
        .alloc_ready    (alloc_ready),
        .alloc_tag      (alloc_tag),
        .alu_done       (alu_done),
        .alu_tag        (alu_tag),
        .alu_data       (alu_data),
        .alu_taken      (alu_taken),
        .mul_done       (mul_done),
        .mul_tag        (mul_tag),
        .mul_data       (mul_data),
        .ret_en         (ret_en),
        .ret_rd         (ret_rd),
        .ret_data       (ret_data),
        .ret_wb         (ret_wb),
        .ret_mispredict (ret_mispredict)
    );

    retire_stage i_retire (
        .clk            (clk),
        .rst            (rst),
        .ret_en         (ret_en),
        .ret_rd         (ret_rd),
        .ret_data       (ret_data),
        .ret_wb         (ret_wb),
        .ret_mispredict (ret_mispredict),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .flush          (flush),
        .rf_addr        (rf_addr),
        .rf_data        (rf_data)
    );

endmodule

//--- tb_ooo_backend.sv
`timescale 1ns/10ps

module tb_ooo_backend;

    localparam int RESET_CYCLES = 10;
    localparam int N_ALU = 40;
    localparam int N_MIX = 40;
    localparam int N_BR = 40;
    localparam int N_BP = 30;
    localparam int N_INSTR = N_ALU + N_MIX + N_BR + N_BP + rob_pkg::NUM_REGS;
    localparam int WATCHDOG_CYCLES = N_INSTR * 20 + RESET_CYCLES;

    typedef struct packed {
        logic                       wb;
        logic                       mis; // branch with the wrong prediction
        logic [rob_pkg::REG_W-1:0]  rd;
        logic [rob_pkg::DATA_W-1:0] res;
    } entry_t;

    logic                       clk;
    logic                       rst;
    logic                       in_valid;
    logic                       in_ready;
    rob_pkg::op_e               in_op;
    logic [rob_pkg::REG_W-1:0]  in_rd;
    logic [rob_pkg::DATA_W-1:0] in_a;
    logic [rob_pkg::DATA_W-1:0] in_b;
    logic                       in_pred_taken;
    logic                       commit_valid;
    logic [rob_pkg::REG_W-1:0]  commit_rd;
    logic [rob_pkg::DATA_W-1:0] commit_data;
    logic                       flush;
    logic [rob_pkg::REG_W-1:0]  rf_addr;
    logic [rob_pkg::DATA_W-1:0] rf_data;

    // in-order reference model
    entry_t                     model_q[$];
    entry_t                     acc_e;
    entry_t                     head_e;
    logic [rob_pkg::DATA_W-1:0] model_rf [rob_pkg::NUM_REGS];

    int unsigned seed;
    int err_count;
    int check_count;
    int tests_run;
    int tests_failed;
    int test_err_base;
    int n_sent;
    int n_wr_accepted;
    int n_wr_squashed;
    int n_commits;
    int n_flushes;
    int n_stalls;

    ooo_backend_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_op         (in_op),
        .in_rd         (in_rd),
        .in_a          (in_a),
        .in_b          (in_b),
        .in_pred_taken (in_pred_taken),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_data   (commit_data),
        .flush         (flush),
        .rf_addr       (rf_addr),
        .rf_data       (rf_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles, commits stopped arriving", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic flag_failure(input string msg);
        err_count++;
        $display("%0t: %s", $time, msg);
    endtask

    function automatic logic [rob_pkg::DATA_W-1:0] expected_result(input rob_pkg::op_e op,
            input logic [rob_pkg::DATA_W-1:0] a, input logic [rob_pkg::DATA_W-1:0] b);
        case (op)
            rob_pkg::OP_ADD: return a + b;
            rob_pkg::OP_SUB: return a - b;
            rob_pkg::OP_XOR: return a ^ b;
            rob_pkg::OP_MUL: return a * b; // low word of the product
            default:         return '0;
        endcase
    endfunction

    // visible events still owed by the DUT
    function automatic int pending_events();
        int n = 0;
        foreach (model_q[i]) begin
            if (model_q[i].mis) return n + 1; // rest gets squashed
            if (model_q[i].wb) n++;
        end
        return n;
    endfunction

    function automatic rob_pkg::op_e random_alu_op();
        case ($urandom_range(2, 0))
            0:       return rob_pkg::OP_ADD;
            1:       return rob_pkg::OP_SUB;
            default: return rob_pkg::OP_XOR;
        endcase
    endfunction

    // monitor sees pre-edge values
    always @(posedge clk) begin
        if (!rst) begin
            if (in_valid && !in_ready) n_stalls++;
            if (flush || commit_valid) begin
                while (model_q.size() > 0 && !model_q[0].wb && !model_q[0].mis)
                    void'(model_q.pop_front());
            end
            if (flush) begin
                n_flushes++;
                if (model_q.size() == 0 || !model_q[0].mis) begin
                    flag_failure("flush raised without a mispredicted branch at the head");
                end else begin
                    void'(model_q.pop_front());
                    foreach (model_q[i]) if (model_q[i].wb) n_wr_squashed++;
                    model_q.delete();
                end
            end
            if (commit_valid) begin
                n_commits++;
                if (model_q.size() == 0) begin
                    flag_failure("commit with no instruction outstanding");
                end else if (model_q[0].mis) begin
                    flag_failure("instruction committed past a mispredicted branch");
                end else begin
                    head_e = model_q.pop_front();
                    check_value("commit_rd", commit_rd, head_e.rd);
                    check_value("commit_data", commit_data, head_e.res);
                    model_rf[head_e.rd] = head_e.res;
                end
            end
            if (in_valid && in_ready) begin
                acc_e.wb  = (in_op != rob_pkg::OP_BEQ);
                acc_e.mis = !acc_e.wb && (in_pred_taken != (in_a == in_b));
                acc_e.rd  = in_rd;
                acc_e.res = expected_result(in_op, in_a, in_b);
                if (acc_e.wb) n_wr_accepted++;
                model_q.push_back(acc_e);
            end
        end
    end

    // called on a falling edge and returns on the one after acceptance
    task automatic send_instr(input rob_pkg::op_e op, input logic [rob_pkg::REG_W-1:0] rd,
                              input logic [rob_pkg::DATA_W-1:0] a,
                              input logic [rob_pkg::DATA_W-1:0] b, input logic pred);
        in_valid      = 1'b1;
        in_op         = op;
        in_rd         = rd;
        in_a          = a;
        in_b          = b;
        in_pred_taken = pred;
        n_sent++;
        do @(posedge clk); while (!in_ready);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        in_valid = 1'b0;
        while (pending_events() != 0) @(negedge clk);
        repeat (8) @(negedge clk); // silent branches leave the buffer
        model_q.delete();
    endtask

    task automatic start_test();
        test_err_base = err_count;
        n_sent        = 0;
        n_wr_accepted = 0;
        n_wr_squashed = 0;
        n_commits     = 0;
        n_flushes     = 0;
        n_stalls      = 0;
    endtask

    task automatic finish_test(input int id, input string name);
        int errs;
        check_value("commit count", n_commits, n_wr_accepted - n_wr_squashed);
        errs = err_count - test_err_base;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %0d %s: %s, %0d sent, %0d commits, %0d flushes, %0d stall cycles",
                 id, name, (errs == 0) ? "ok" : "FAILED", n_sent, n_commits, n_flushes,
                 n_stalls);
    endtask

    initial begin
        rob_pkg::op_e               op;
        logic [rob_pkg::DATA_W-1:0] a;
        logic [rob_pkg::DATA_W-1:0] b;
        seed = 32'ha950;
        void'($urandom(seed));
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_op         = rob_pkg::OP_ADD;
        in_rd         = '0;
        in_a          = '0;
        in_b          = '0;
        in_pred_taken = 1'b0;
        rf_addr       = '0;
        foreach (model_rf[r]) model_rf[r] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        start_test();
        for (int i = 0; i < N_ALU; i++) begin
            send_instr(random_alu_op(), $urandom_range(15, 0), $urandom(), $urandom(), 1'b0);
            if ($urandom_range(3, 0) == 0) @(negedge clk); // occasional bubble
        end
        drain();
        finish_test(1, "alu stream");

        // back to back so products finish behind younger alu ops
        start_test();
        for (int i = 0; i < N_MIX; i++) begin
            op = ($urandom_range(1, 0) == 1) ? rob_pkg::OP_MUL : random_alu_op();
            send_instr(op, $urandom_range(15, 0), $urandom(), $urandom(), 1'b0);
        end
        drain();
        finish_test(2, "mixed mul/alu");

        start_test();
        for (int i = 0; i < N_BR; i++) begin
            a = $urandom();
            if ($urandom_range(2, 0) == 0) begin
                b = ($urandom_range(1, 0) == 1) ? a : $urandom();
                send_instr(rob_pkg::OP_BEQ, '0, a, b, $urandom_range(1, 0));
            end else begin
                send_instr(random_alu_op(), $urandom_range(15, 0), a, $urandom(), 1'b0);
            end
        end
        drain();
        finish_test(3, "branches");

        start_test();
        for (int i = 0; i < N_BP; i++) begin
            a = $urandom();
            if (i % 10 == 9) begin
                send_instr(rob_pkg::OP_BEQ, '0, a, a, 1'b0); // taken but guessed not taken
            end else begin
                op = ($urandom_range(3, 0) != 0) ? rob_pkg::OP_MUL : random_alu_op();
                send_instr(op, $urandom_range(15, 0), a, $urandom(), 1'b0);
            end
        end
        drain();
        if (n_stalls == 0) flag_failure("in_ready never dropped while in_valid was held");
        finish_test(4, "back-pressure");

        start_test();
        for (int r = 0; r < rob_pkg::NUM_REGS; r++) begin
            rf_addr = r[rob_pkg::REG_W-1:0];
            @(posedge clk);
            check_value($sformatf("rf_data[%0d]", r), rf_data, model_rf[r]);
            @(negedge clk);
        end
        finish_test(5, "register file");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
rob_pkg.sv
dispatch_stage.sv
exec_stage.sv
reorder_buffer.sv
retire_stage.sv
ooo_backend_top.sv
tb_ooo_backend.sv

//--- Bender.yml
package:
  name: ooo_backend

sources:
  - rob_pkg.sv
  - dispatch_stage.sv
  - exec_stage.sv
  - reorder_buffer.sv
  - retire_stage.sv
  - ooo_backend_top.sv
  - target: simulation
    files:
      - tb_ooo_backend.sv
